/* hw/lc4_defs.svh */
`ifndef LC4_DEFS_SVH
`define LC4_DEFS_SVH

// datapath width and register count
`define LC4_XLEN        16
`define LC4_NREGS       8

// first fetch address out of reset
`define LC4_RESET_PC    16'h8200

// opcode field, insn[15:12]
`define LC4_OP_BR       4'b0000
`define LC4_OP_ARITH    4'b0001
`define LC4_OP_LOGIC    4'b0101
`define LC4_OP_LDR      4'b0110
`define LC4_OP_STR      4'b0111
`define LC4_OP_CONST    4'b1001
`define LC4_OP_JMP      4'b1100

// stall codes carried down the pipe and out on the retire trace
`define LC4_STALL_NONE      2'd0
`define LC4_STALL_PIPE      2'd1
`define LC4_STALL_BRANCH    2'd2
`define LC4_STALL_LOAD      2'd3

// execute operand source
`define LC4_BYP_NONE    2'd0
`define LC4_BYP_M       2'd1
`define LC4_BYP_W       2'd2

`endif

/* hw/lc4_pkg.sv */
`default_nettype none

`include "lc4_defs.svh"

package lc4_pkg;

    typedef logic [1:0] stall_t;

    // register-register layout of ARITH and LOGIC
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] sub_op;
        logic [2:0] rt;
    } insn_alu_t;

    // immediate layout, also used by LDR, STR and JMPR
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [5:0] imm6;
    } insn_imm_t;

    // branch layout; CONST keeps its rd where the mask sits
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] nzp;
        logic [8:0] off9;
    } insn_br_t;

    typedef union packed {
        insn_alu_t alu;
        insn_imm_t imm;
        insn_br_t  br;
    } insn_u;

    typedef struct packed {
        logic [2:0] rs_sel;
        logic [2:0] rt_sel;
        logic [2:0] rd_sel;
        logic       rs_re;
        logic       rt_re;
        logic       rd_we;
        logic       nzp_we;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_jump;
    } ctrl_t;

    typedef struct packed {
        stall_t                stall;
        logic [`LC4_XLEN-1:0]  pc;
        insn_u                 insn;
        ctrl_t                 ctrl;
        logic [`LC4_XLEN-1:0]  rs_data;
        logic [`LC4_XLEN-1:0]  rt_data;
    } dx_t;

    typedef struct packed {
        stall_t                stall;
        logic [`LC4_XLEN-1:0]  pc;
        insn_u                 insn;
        ctrl_t                 ctrl;
        logic [`LC4_XLEN-1:0]  result;
        logic [`LC4_XLEN-1:0]  store_data;
    } xm_t;

    typedef struct packed {
        stall_t                stall;
        logic [`LC4_XLEN-1:0]  pc;
        insn_u                 insn;
        ctrl_t                 ctrl;
        logic [`LC4_XLEN-1:0]  result;
        logic [`LC4_XLEN-1:0]  load_data;
        logic [2:0]            nzp;
    } mw_t;

    // one writeback-stage record per cycle
    typedef struct packed {
        logic                  valid;
        stall_t                stall;
        logic [`LC4_XLEN-1:0]  pc;
        logic [`LC4_XLEN-1:0]  insn;
        logic                  rd_we;
        logic [2:0]            wsel;
        logic [`LC4_XLEN-1:0]  wdata;
        logic                  nzp_we;
        logic [2:0]            nzp;
    } retire_t;

endpackage

`default_nettype wire

/* hw/lc4_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lc4_defs.svh"

module lc4_decoder (
    input  wire lc4_pkg::insn_u  i_insn,
    output lc4_pkg::ctrl_t       o_ctrl
);

    logic imm_form;
    logic alu_supported;

    // bit 5 picks the immediate form of ARITH and LOGIC
    assign imm_form = i_insn.imm.imm6[5];

    // MUL, DIV and NOT are not part of this core
    always_comb begin
        if (imm_form) begin
            alu_supported = 1'b1;
        end else if (i_insn.alu.opcode == `LC4_OP_ARITH) begin
            alu_supported = (i_insn.alu.sub_op == 3'b000) || (i_insn.alu.sub_op == 3'b010);
        end else begin
            alu_supported = (i_insn.alu.sub_op != 3'b001);
        end
    end

    always_comb begin
        o_ctrl = '0;
        case (i_insn.alu.opcode)
            `LC4_OP_ARITH, `LC4_OP_LOGIC: begin
                if (alu_supported) begin
                    o_ctrl.rd_sel = i_insn.alu.rd;
                    o_ctrl.rs_sel = i_insn.alu.rs;
                    o_ctrl.rt_sel = i_insn.alu.rt;
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = !imm_form;
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            `LC4_OP_LDR: begin
                o_ctrl.rd_sel  = i_insn.imm.rd;
                o_ctrl.rs_sel  = i_insn.imm.rs;
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            `LC4_OP_STR: begin
                // store data register lives in the rd field
                o_ctrl.rt_sel   = i_insn.imm.rd;
                o_ctrl.rs_sel   = i_insn.imm.rs;
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            `LC4_OP_CONST: begin
                // rd shares its position with the branch mask
                o_ctrl.rd_sel = i_insn.br.nzp;
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            `LC4_OP_BR: begin
                o_ctrl.is_branch = 1'b1;
            end
            `LC4_OP_JMP: begin
                // JMPR only, the pc-relative form stays a no-op
                if (!i_insn.imm.rd[2]) begin
                    o_ctrl.rs_sel  = i_insn.imm.rs;
                    o_ctrl.rs_re   = 1'b1;
                    o_ctrl.is_jump = 1'b1;
                end
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/lc4_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lc4_defs.svh"

module lc4_regfile (
    input  wire                   gwe,
    input  wire                   i_reset,
    input  wire [2:0]             i_rs_sel,
    input  wire [2:0]             i_rt_sel,
    input  wire [2:0]             i_rd_sel,
    input  wire                   i_rd_we,
    input  wire [`LC4_XLEN-1:0]   i_rd_data,
    output logic [`LC4_XLEN-1:0]  o_rs_data,
    output logic [`LC4_XLEN-1:0]  o_rt_data
);

    logic [`LC4_XLEN-1:0] regs [`LC4_NREGS];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < `LC4_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // writeback in the same cycle shows through to decode
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

    // whatever path fed writeback, the value must be resolved
    assert property (@(posedge gwe) disable iff (i_reset)
        i_rd_we |-> !$isunknown({i_rd_sel, i_rd_data}));

endmodule

`default_nettype wire

/* hw/lc4_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lc4_defs.svh"

module lc4_alu (
    input  wire lc4_pkg::insn_u   i_insn,
    input  wire [`LC4_XLEN-1:0]   i_pc,
    input  wire [`LC4_XLEN-1:0]   i_rs_data,
    input  wire [`LC4_XLEN-1:0]   i_rt_data,
    output logic [`LC4_XLEN-1:0]  o_result
);

    logic [`LC4_XLEN-1:0] imm5_sext;
    logic [`LC4_XLEN-1:0] imm6_sext;
    logic [`LC4_XLEN-1:0] imm9_sext;
    logic [`LC4_XLEN-1:0] operand_b;

    assign imm5_sext = {{(`LC4_XLEN-5){i_insn.imm.imm6[4]}}, i_insn.imm.imm6[4:0]};
    assign imm6_sext = {{(`LC4_XLEN-6){i_insn.imm.imm6[5]}}, i_insn.imm.imm6};
    assign imm9_sext = {{(`LC4_XLEN-9){i_insn.br.off9[8]}}, i_insn.br.off9};

    // immediate form replaces rt
    assign operand_b = i_insn.imm.imm6[5] ? imm5_sext : i_rt_data;

    always_comb begin
        case (i_insn.alu.opcode)
            `LC4_OP_ARITH: begin
                if (i_insn.alu.sub_op == 3'b010) begin
                    o_result = i_rs_data - i_rt_data;
                end else begin
                    o_result = i_rs_data + operand_b;
                end
            end
            `LC4_OP_LOGIC: begin
                case (i_insn.alu.sub_op)
                    3'b010:  o_result = i_rs_data | i_rt_data;
                    3'b011:  o_result = i_rs_data ^ i_rt_data;
                    default: o_result = i_rs_data & operand_b;
                endcase
            end
            `LC4_OP_LDR, `LC4_OP_STR: begin
                o_result = i_rs_data + imm6_sext;
            end
            `LC4_OP_CONST: begin
                o_result = imm9_sext;
            end
            `LC4_OP_BR: begin
                // branch target, used only when taken
                o_result = i_pc + 1'b1 + imm9_sext;
            end
            `LC4_OP_JMP: begin
                o_result = i_rs_data;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/lc4_hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lc4_defs.svh"

module lc4_hazard_unit (
    input  wire lc4_pkg::ctrl_t  i_d_ctrl,
    input  wire lc4_pkg::ctrl_t  i_x_ctrl,
    input  wire lc4_pkg::ctrl_t  i_m_ctrl,
    input  wire lc4_pkg::ctrl_t  i_w_ctrl,
    input  wire                  i_x_taken,
    output logic                 o_load_stall,
    output logic                 o_flush,
    output logic [1:0]           o_rs_bypass,
    output logic [1:0]           o_rt_bypass,
    output logic                 o_store_bypass
);

    logic rs_hit;
    logic rt_hit;

    // memory stage is younger, so it wins over writeback
    function automatic logic [1:0] bypass_sel(input logic re, input logic [2:0] sel,
                                              input lc4_pkg::ctrl_t m,
                                              input lc4_pkg::ctrl_t w);
        if (re && m.rd_we && m.rd_sel == sel) begin
            return `LC4_BYP_M;
        end else if (re && w.rd_we && w.rd_sel == sel) begin
            return `LC4_BYP_W;
        end
        return `LC4_BYP_NONE;
    endfunction

    assign rs_hit = i_d_ctrl.rs_re && i_d_ctrl.rs_sel == i_x_ctrl.rd_sel;
    // store data is picked up later on the WM path
    assign rt_hit = i_d_ctrl.rt_re && !i_d_ctrl.is_store && i_d_ctrl.rt_sel == i_x_ctrl.rd_sel;

    assign o_load_stall = i_x_ctrl.is_load && i_x_ctrl.rd_we && (rs_hit || rt_hit);

    // taken branch or any JMPR squashes fetch and decode
    assign o_flush = i_x_taken || i_x_ctrl.is_jump;

    assign o_rs_bypass = bypass_sel(i_x_ctrl.rs_re, i_x_ctrl.rs_sel, i_m_ctrl, i_w_ctrl);
    assign o_rt_bypass = bypass_sel(i_x_ctrl.rt_re, i_x_ctrl.rt_sel, i_m_ctrl, i_w_ctrl);

    assign o_store_bypass = i_m_ctrl.is_store && i_w_ctrl.rd_we &&
                            i_w_ctrl.rd_sel == i_m_ctrl.rt_sel;

    // a load in execute is never also a redirect, so stall and flush cannot collide
    always_comb begin
        assert final (!(i_x_ctrl.is_load && (i_x_ctrl.is_branch || i_x_ctrl.is_jump)));
    end

endmodule

`default_nettype wire

/* hw/lc4_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lc4_defs.svh"

module lc4_core (
    input  wire                    gwe,
    input  wire                    i_reset,
    output logic [`LC4_XLEN-1:0]   o_cur_pc,
    input  wire [`LC4_XLEN-1:0]    i_cur_insn,
    output logic [`LC4_XLEN-1:0]   o_dmem_addr,
    output logic [`LC4_XLEN-1:0]   o_dmem_towrite,
    output logic                   o_dmem_we,
    input  wire [`LC4_XLEN-1:0]    i_cur_dmem_data,
    output lc4_pkg::retire_t       o_retire
);

    logic [`LC4_XLEN-1:0] pc_q;
    logic [`LC4_XLEN-1:0] pc_next;
    logic [`LC4_XLEN-1:0] d_pc;
    lc4_pkg::insn_u       d_insn;
    lc4_pkg::stall_t      d_stall;
    lc4_pkg::ctrl_t       d_ctrl;
    lc4_pkg::dx_t         x_q;
    lc4_pkg::dx_t         x_next;
    lc4_pkg::xm_t         m_q;
    lc4_pkg::mw_t         w_q;
    logic [`LC4_XLEN-1:0] rs_data;
    logic [`LC4_XLEN-1:0] rt_data;
    logic [`LC4_XLEN-1:0] x_rs;
    logic [`LC4_XLEN-1:0] x_rt;
    logic [`LC4_XLEN-1:0] alu_result;
    logic [`LC4_XLEN-1:0] m_value;
    logic [`LC4_XLEN-1:0] w_data;
    logic [2:0]           nzp_q;
    logic [2:0]           nzp_branch;
    logic [2:0]           m_nzp;
    logic                 x_taken;
    logic                 load_stall;
    logic                 flush;
    logic                 store_bypass;
    logic [1:0]           rs_bypass;
    logic [1:0]           rt_bypass;

    function automatic logic [`LC4_XLEN-1:0] bypass_mux(input logic [1:0] sel,
                                                        input logic [`LC4_XLEN-1:0] rf_val,
                                                        input logic [`LC4_XLEN-1:0] m_val,
                                                        input logic [`LC4_XLEN-1:0] w_val);
        case (sel)
            `LC4_BYP_M: return m_val;
            `LC4_BYP_W: return w_val;
            default:    return rf_val;
        endcase
    endfunction

    // fetch: redirect beats the load-use hold
    assign o_cur_pc = pc_q;
    assign pc_next  = flush ? alu_result : (load_stall ? pc_q : pc_q + 1'b1);

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc_q    <= `LC4_RESET_PC;
            d_insn  <= '0;
            d_stall <= `LC4_STALL_BRANCH;
        end else begin
            pc_q <= pc_next;
            if (flush) begin
                d_insn  <= '0;
                d_stall <= `LC4_STALL_BRANCH;
            end else if (!load_stall) begin
                d_insn  <= i_cur_insn;
                d_stall <= `LC4_STALL_NONE;
            end
        end
    end

    always_ff @(posedge gwe) begin
        if (!load_stall) begin
            d_pc <= pc_q;
        end
    end

    // decode
    lc4_decoder decoder_i (
        .i_insn (d_insn),
        .o_ctrl (d_ctrl)
    );

    lc4_regfile regfile_i (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_rs_sel  (d_ctrl.rs_sel),
        .i_rt_sel  (d_ctrl.rt_sel),
        .i_rd_sel  (w_q.ctrl.rd_sel),
        .i_rd_we   (w_q.ctrl.rd_we),
        .i_rd_data (w_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    lc4_hazard_unit hazard_i (
        .i_d_ctrl       (d_ctrl),
        .i_x_ctrl       (x_q.ctrl),
        .i_m_ctrl       (m_q.ctrl),
        .i_w_ctrl       (w_q.ctrl),
        .i_x_taken      (x_taken),
        .o_load_stall   (load_stall),
        .o_flush        (flush),
        .o_rs_bypass    (rs_bypass),
        .o_rt_bypass    (rt_bypass),
        .o_store_bypass (store_bypass)
    );

    always_comb begin
        x_next = '0;
        if (flush) begin
            x_next.stall = `LC4_STALL_BRANCH;
        end else if (load_stall) begin
            x_next.stall = `LC4_STALL_LOAD;
        end else begin
            x_next.stall   = d_stall;
            x_next.pc      = d_pc;
            x_next.insn    = d_insn;
            x_next.ctrl    = d_ctrl;
            x_next.rs_data = rs_data;
            x_next.rt_data = rt_data;
        end
    end

    // execute
    assign x_rs = bypass_mux(rs_bypass, x_q.rs_data, m_q.result, w_data);
    assign x_rt = bypass_mux(rt_bypass, x_q.rt_data, m_q.result, w_data);

    lc4_alu alu_i (
        .i_insn    (x_q.insn),
        .i_pc      (x_q.pc),
        .i_rs_data (x_rs),
        .i_rt_data (x_rt),
        .o_result  (alu_result)
    );

    // condition codes of older instructions still in flight
    assign nzp_branch = m_q.ctrl.nzp_we ? m_nzp : (w_q.ctrl.nzp_we ? w_q.nzp : nzp_q);
    assign x_taken    = x_q.ctrl.is_branch && |(nzp_branch & x_q.insn.br.nzp);

    // memory
    assign o_dmem_addr    = m_q.result;
    assign o_dmem_we      = m_q.ctrl.is_store;
    assign o_dmem_towrite = store_bypass ? w_data : m_q.store_data;
    assign m_value        = m_q.ctrl.is_load ? i_cur_dmem_data : m_q.result;
    assign m_nzp          = ($signed(m_value) > 0) ? 3'b001 : ((m_value == '0) ? 3'b010 : 3'b100);

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            x_q <= '{stall: `LC4_STALL_BRANCH, default: '0};
            m_q <= '{stall: `LC4_STALL_BRANCH, default: '0};
            w_q <= '{stall: `LC4_STALL_BRANCH, default: '0};
        end else begin
            x_q <= x_next;
            m_q <= '{stall: x_q.stall, pc: x_q.pc, insn: x_q.insn, ctrl: x_q.ctrl,
                     result: alu_result, store_data: x_rt};
            w_q <= '{stall: m_q.stall, pc: m_q.pc, insn: m_q.insn, ctrl: m_q.ctrl,
                     result: m_q.result, load_data: i_cur_dmem_data, nzp: m_nzp};
        end
    end

    // writeback
    assign w_data = w_q.ctrl.is_load ? w_q.load_data : w_q.result;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            nzp_q <= 3'b010;
        end else if (w_q.ctrl.nzp_we) begin
            nzp_q <= w_q.nzp;
        end
    end

    always_comb begin
        o_retire.valid  = (w_q.stall == `LC4_STALL_NONE);
        o_retire.stall  = w_q.stall;
        o_retire.pc     = w_q.pc;
        o_retire.insn   = w_q.insn;
        o_retire.rd_we  = w_q.ctrl.rd_we;
        o_retire.wsel   = w_q.ctrl.rd_sel;
        o_retire.wdata  = w_data;
        o_retire.nzp_we = w_q.ctrl.nzp_we;
        o_retire.nzp    = w_q.nzp;
    end

    // a write on the data port comes only from a real STR
    assert property (@(posedge gwe) disable iff (i_reset)
        o_dmem_we |-> (m_q.insn.alu.opcode == `LC4_OP_STR) && (m_q.stall == `LC4_STALL_NONE));

endmodule

`default_nettype wire

/* sim/lc4_tb_programs.svh */
`ifndef LC4_TB_PROGRAMS_SVH
`define LC4_TB_PROGRAMS_SVH

// encoders for the supported subset
function automatic logic [15:0] alu_word(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs, input logic [2:0] sub,
                                         input logic [2:0] rt);
    return {op, rd, rs, sub, rt};
endfunction

function automatic logic [15:0] imm_word(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs, input logic [5:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic logic [15:0] const_word(input logic [2:0] rd, input logic [8:0] imm);
    return {`LC4_OP_CONST, rd, imm};
endfunction

function automatic logic [15:0] br_word(input logic [2:0] mask, input logic [8:0] off);
    return {`LC4_OP_BR, mask, off};
endfunction

// low bits of v taken as a signed field
function automatic logic [15:0] sign_extend(input logic [15:0] v, input int bits);
    logic [15:0] t;
    t = v << (16 - bits);
    return $signed(t) >>> (16 - bits);
endfunction

function automatic logic [2:0] nzp_of(input logic [15:0] v);
    if (v == 16'h0000) begin
        return 3'b010;
    end
    return v[15] ? 3'b100 : 3'b001;
endfunction

task automatic emit(input logic [15:0] w);
    imem[prog_len] = w;
    prog_len++;
endtask

task automatic reset_program();
    emit(const_word(3'd1, 9'd5));
    emit(const_word(3'd2, 9'h1fd));
    emit(alu_word(`LC4_OP_ARITH, 3'd3, 3'd1, 3'b000, 3'd2));
endtask

// every instruction reads the one before it
task automatic alu_chain_program();
    emit(const_word(3'd1, 9'd100));
    emit(const_word(3'd2, 9'h1f9));
    emit(alu_word(`LC4_OP_ARITH, 3'd3, 3'd1, 3'b000, 3'd2));
    emit(alu_word(`LC4_OP_ARITH, 3'd4, 3'd3, 3'b010, 3'd1));
    emit(alu_word(`LC4_OP_LOGIC, 3'd5, 3'd4, 3'b000, 3'd3));
    emit(alu_word(`LC4_OP_LOGIC, 3'd6, 3'd5, 3'b010, 3'd2));
    emit(alu_word(`LC4_OP_LOGIC, 3'd7, 3'd6, 3'b011, 3'd6));
    emit(imm_word(`LC4_OP_ARITH, 3'd1, 3'd7, 6'h30));
    emit(imm_word(`LC4_OP_LOGIC, 3'd2, 3'd1, 6'h2c));
    emit(alu_word(`LC4_OP_ARITH, 3'd3, 3'd3, 3'b000, 3'd3));
    emit(const_word(3'd0, 9'd0));
    emit(alu_word(`LC4_OP_ARITH, 3'd0, 3'd0, 3'b010, 3'd1));
endtask

task automatic load_store_program();
    emit(const_word(3'd1, 9'd16));
    emit(const_word(3'd2, 9'h055));
    emit(imm_word(`LC4_OP_STR, 3'd2, 3'd1, 6'd3));
    emit(imm_word(`LC4_OP_LDR, 3'd3, 3'd1, 6'd3));
    // load-use bubble here
    emit(alu_word(`LC4_OP_ARITH, 3'd4, 3'd3, 3'b000, 3'd3));
    emit(imm_word(`LC4_OP_STR, 3'd4, 3'd1, 6'd4));
    emit(imm_word(`LC4_OP_LDR, 3'd5, 3'd1, 6'd4));
    // load result goes straight into store data
    emit(imm_word(`LC4_OP_STR, 3'd5, 3'd1, 6'd5));
    emit(imm_word(`LC4_OP_LDR, 3'd6, 3'd1, 6'd5));
    emit(imm_word(`LC4_OP_LDR, 3'd7, 3'd6, 6'd0));
    emit(imm_word(`LC4_OP_ARITH, 3'd7, 3'd7, 6'h21));
    emit(imm_word(`LC4_OP_LDR, 3'd0, 3'd1, 6'h3e));
    emit(alu_word(`LC4_OP_ARITH, 3'd2, 3'd0, 3'b000, 3'd7));
endtask

task automatic branch_program();
    int target;
    // each mask against a negative, zero and positive condition
    for (int c = 0; c < 3; c++) begin
        for (int m = 1; m < 8; m++) begin
            emit(const_word(3'd0, (c == 0) ? 9'h1ff : 9'(c - 1)));
            emit(br_word(m[2:0], 9'd1));
            emit(const_word(3'd7, 9'(m)));
        end
    end
    // countdown loop, backward branch on the fresh NZP
    emit(const_word(3'd1, 9'd3));
    emit(imm_word(`LC4_OP_ARITH, 3'd1, 3'd1, 6'h3f));
    emit(br_word(3'b001, 9'h1fe));
    // build 0x8200 by doubling, then add the target index
    emit(const_word(3'd6, 9'h082));
    repeat (8) emit(alu_word(`LC4_OP_ARITH, 3'd6, 3'd6, 3'b000, 3'd6));
    target = prog_len + 5;
    emit(const_word(3'd5, 9'(target)));
    emit(alu_word(`LC4_OP_ARITH, 3'd6, 3'd6, 3'b000, 3'd5));
    emit(imm_word(`LC4_OP_JMP, 3'd0, 3'd6, 6'd0));
    emit(const_word(3'd4, 9'd1));
    emit(const_word(3'd4, 9'd2));
    emit(const_word(3'd4, 9'd77));
endtask

// r7 stays the base, so addresses land in 32..95
task automatic random_program();
    int kind;
    logic [2:0] rd;
    logic [2:0] rs;
    logic [2:0] rt;
    emit(const_word(3'd7, 9'd64));
    repeat (200) begin
        kind = $urandom % 10;
        rd = 3'($urandom % 7);
        rs = 3'($urandom);
        rt = 3'($urandom);
        case (kind)
            0: emit(alu_word(`LC4_OP_ARITH, rd, rs, 3'b000, rt));
            1: emit(alu_word(`LC4_OP_ARITH, rd, rs, 3'b010, rt));
            2: emit(alu_word(`LC4_OP_LOGIC, rd, rs, 3'b000, rt));
            3: emit(alu_word(`LC4_OP_LOGIC, rd, rs, 3'b010, rt));
            4: emit(alu_word(`LC4_OP_LOGIC, rd, rs, 3'b011, rt));
            5: emit(imm_word(`LC4_OP_ARITH, rd, rs, {1'b1, 5'($urandom)}));
            6: emit(imm_word(`LC4_OP_LOGIC, rd, rs, {1'b1, 5'($urandom)}));
            7: emit(const_word(rd, 9'($urandom)));
            8: emit(imm_word(`LC4_OP_LDR, rd, 3'd7, 6'($urandom)));
            default: emit(imm_word(`LC4_OP_STR, rt, 3'd7, 6'($urandom)));
        endcase
    end
endtask

// one ISA step of the software model at ref_pc
function automatic lc4_pkg::retire_t lc4_ref_step();
    lc4_pkg::retire_t expected;
    logic [15:0] insn;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] val;
    logic [15:0] addr;
    logic [15:0] next_pc;
    logic        wr;
    insn = imem[ref_pc[7:0]];
    a = ref_regs[insn[8:6]];
    b = insn[5] ? sign_extend(insn, 5) : ref_regs[insn[2:0]];
    addr = a + sign_extend(insn, 6);
    expected = '0;
    expected.valid = 1'b1;
    expected.pc = ref_pc;
    expected.insn = insn;
    next_pc = ref_pc + 16'd1;
    wr = 1'b0;
    val = '0;
    ref_st_valid = 1'b0;
    case (insn[15:12])
        `LC4_OP_ARITH: begin
            wr = 1'b1;
            val = (insn[5:3] == 3'b010) ? a - b : a + b;
        end
        `LC4_OP_LOGIC: begin
            wr = 1'b1;
            if (insn[5:3] == 3'b010) begin
                val = a | b;
            end else if (insn[5:3] == 3'b011) begin
                val = a ^ b;
            end else begin
                val = a & b;
            end
        end
        `LC4_OP_LDR: begin
            wr = 1'b1;
            val = ref_dmem[addr[7:0]];
        end
        `LC4_OP_STR: begin
            ref_st_valid = 1'b1;
            ref_st_addr = addr;
            ref_st_data = ref_regs[insn[11:9]];
            ref_dmem[addr[7:0]] = ref_st_data;
        end
        `LC4_OP_CONST: begin
            wr = 1'b1;
            val = sign_extend(insn, 9);
        end
        `LC4_OP_BR: begin
            if ((ref_nzp & insn[11:9]) != 3'b000) begin
                next_pc = ref_pc + 16'd1 + sign_extend(insn, 9);
            end
        end
        `LC4_OP_JMP: begin
            next_pc = a;
        end
        default: begin
        end
    endcase
    if (wr) begin
        expected.rd_we = 1'b1;
        expected.wsel = insn[11:9];
        expected.wdata = val;
        expected.nzp_we = 1'b1;
        expected.nzp = nzp_of(val);
        ref_regs[insn[11:9]] = val;
        ref_nzp = expected.nzp;
    end
    ref_pc = next_pc;
    return expected;
endfunction

`endif

/* sim/lc4_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lc4_defs.svh"

module lc4_core_tb;

    logic                  gwe;
    logic                  i_reset;
    logic [`LC4_XLEN-1:0]  cur_pc;
    logic [`LC4_XLEN-1:0]  cur_insn;
    logic [`LC4_XLEN-1:0]  dmem_addr;
    logic [`LC4_XLEN-1:0]  dmem_towrite;
    logic                  dmem_we;
    logic [`LC4_XLEN-1:0]  dmem_rdata;
    lc4_pkg::retire_t      retire;

    // both memories decode only the low address byte
    logic [15:0]  imem [0:255];
    logic [15:0]  dmem [0:255];

    // software model state
    logic [15:0]  ref_dmem [0:255];
    logic [15:0]  ref_regs [0:7];
    logic [2:0]   ref_nzp;
    logic [15:0]  ref_pc;
    logic         ref_st_valid;
    logic [15:0]  ref_st_addr;
    logic [15:0]  ref_st_data;

    int           prog_len;
    logic [15:0]  final_pc;
    string        test_name;
    int           test_errs;
    int           total_errs;
    int           tests_run;
    int           tests_failed;
    logic         running;
    logic         prog_done;
    logic         timed_out;
    logic         pend_we;
    logic [15:0]  pend_addr;
    logic [15:0]  pend_data;
    logic [31:0]  store_q [$];

    `include "lc4_tb_programs.svh"

    lc4_core dut_i (
        .gwe             (gwe),
        .i_reset         (i_reset),
        .o_cur_pc        (cur_pc),
        .i_cur_insn      (cur_insn),
        .o_dmem_addr     (dmem_addr),
        .o_dmem_towrite  (dmem_towrite),
        .o_dmem_we       (dmem_we),
        .i_cur_dmem_data (dmem_rdata),
        .o_retire        (retire)
    );

    assign cur_insn   = imem[cur_pc[7:0]];
    assign dmem_rdata = dmem[dmem_addr[7:0]];

    always #20 gwe = ~gwe;

    task automatic flag_mismatch(input string what, input logic [15:0] exp_v,
                                 input logic [15:0] act_v);
        $display("ERR %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
        test_errs++;
    endtask

    task automatic compare_retire(input lc4_pkg::retire_t e, input lc4_pkg::retire_t a);
        if (a.pc !== e.pc) flag_mismatch("retired pc", e.pc, a.pc);
        if (a.insn !== e.insn) flag_mismatch("insn", e.insn, a.insn);
        if (a.rd_we !== e.rd_we) flag_mismatch("regfile we", e.rd_we, a.rd_we);
        if (e.rd_we && a.wsel !== e.wsel) flag_mismatch("wsel", e.wsel, a.wsel);
        if (e.rd_we && a.wdata !== e.wdata) flag_mismatch("wdata", e.wdata, a.wdata);
        if (a.nzp_we !== e.nzp_we) flag_mismatch("nzp we", e.nzp_we, a.nzp_we);
        if (e.nzp_we && a.nzp !== e.nzp) flag_mismatch("nzp", e.nzp, a.nzp);
    endtask

    // outputs are settled by the falling edge
    always @(negedge gwe) begin
        lc4_pkg::retire_t expected;
        logic [31:0] st;
        if (running && !i_reset) begin
            if (dmem_we === 1'b1) begin
                store_q.push_back({dmem_addr, dmem_towrite});
                pend_we = 1'b1;
                pend_addr = dmem_addr;
                pend_data = dmem_towrite;
            end
            if (retire.valid === 1'b1) begin
                expected = lc4_ref_step();
                compare_retire(expected, retire);
                if (ref_st_valid && store_q.size() == 0) begin
                    $display("%s: store at pc %h never wrote data memory", test_name, retire.pc);
                    test_errs++;
                end else if (ref_st_valid) begin
                    st = store_q.pop_front();
                    if (st[31:16] !== ref_st_addr) begin
                        flag_mismatch("store addr", ref_st_addr, st[31:16]);
                    end
                    if (st[15:0] !== ref_st_data) begin
                        flag_mismatch("store data", ref_st_data, st[15:0]);
                    end
                end
                if (retire.pc === final_pc) begin
                    prog_done = 1'b1;
                end
            end else if (retire.stall !== `LC4_STALL_BRANCH &&
                         retire.stall !== `LC4_STALL_LOAD) begin
                $display("%s: bubble retired with stall code %0d", test_name, retire.stall);
                test_errs++;
            end
        end
    end

    // data memory takes the write just after the edge that ends the store's M cycle
    always @(posedge gwe) begin
        #1;
        if (pend_we) begin
            dmem[pend_addr[7:0]] = pend_data;
        end
        pend_we = 1'b0;
    end

    task automatic run_program(input string name);
        int cycles;
        test_name = name;
        test_errs = 0;
        final_pc = `LC4_RESET_PC + 16'(prog_len - 1);
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {8'(i) ^ 8'h5a, 8'(i)};
            ref_dmem[i] = dmem[i];
        end
        for (int i = 0; i < 8; i++) begin
            ref_regs[i] = '0;
        end
        ref_nzp = 3'b010;
        ref_pc = `LC4_RESET_PC;
        store_q.delete();
        prog_done = 1'b0;
        i_reset = 1'b1;
        repeat (4) @(posedge gwe);
        #2;
        i_reset = 1'b0;
        if (cur_pc !== `LC4_RESET_PC) flag_mismatch("pc after reset", `LC4_RESET_PC, cur_pc);
        if (dmem_we !== 1'b0) flag_mismatch("dmem we after reset", 16'd0, dmem_we);
        if (retire.valid !== 1'b0) flag_mismatch("retire valid after reset", 16'd0, retire.valid);
        running = 1'b1;
        cycles = 0;
        while (!prog_done && cycles < 2000) begin
            @(posedge gwe);
            #2;
            cycles++;
        end
        running = 1'b0;
        if (!prog_done) begin
            $display("%s: timed out before pc %h retired", name, final_pc);
            timed_out = 1'b1;
            test_errs++;
        end
        for (int i = 0; i < 256; i++) begin
            if (dmem[i] !== ref_dmem[i]) begin
                flag_mismatch($sformatf("dmem[%0d]", i), ref_dmem[i], dmem[i]);
            end
        end
        if (prog_done && store_q.size() != 0) begin
            $display("%s: data memory was written with no matching store", name);
            test_errs++;
        end
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_failed++;
        end
    endtask

    initial begin
        string name;
        gwe = 1'b0;
        i_reset = 1'b1;
        running = 1'b0;
        prog_done = 1'b0;
        timed_out = 1'b0;
        pend_we = 1'b0;
        final_pc = '0;
        total_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(36198));
        for (int t = 0; t < 5 && !timed_out; t++) begin
            // never-taken BR whose offset follows the address
            for (int i = 0; i < 256; i++) begin
                imem[i] = br_word(3'b000, 9'(i));
            end
            prog_len = 0;
            case (t)
                0: begin
                    reset_program();
                    name = "reset";
                end
                1: begin
                    alu_chain_program();
                    name = "alu_bypass";
                end
                2: begin
                    load_store_program();
                    name = "load_store";
                end
                3: begin
                    branch_program();
                    name = "branch_jmpr";
                end
                default: begin
                    random_program();
                    name = "random";
                end
            endcase
            run_program(name);
        end
        $display("tests %0d, failing %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (timed_out || total_errs != 0) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lc4_core.f */
+incdir+hw
+incdir+sim
hw/lc4_pkg.sv
hw/lc4_decoder.sv
hw/lc4_regfile.sv
hw/lc4_alu.sv
hw/lc4_hazard_unit.sv
hw/lc4_core.sv
sim/lc4_core_tb.sv
